// ==== cdp_dp.f ====
+incdir+bench
source/cdp_pkg.sv
source/cdp_cvt_in.sv
source/cdp_sqsum.sv
source/cdp_lut.sv
source/cdp_cvt_out.sv
source/cdp_dp.sv
bench/cdp_dp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the CDP datapath testbench with Verilator, run it, check the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --top-module cdp_dp_tb -f cdp_dp.f -o cdp_dp_sim > build.log 2>&1 &&
./obj_dir/cdp_dp_sim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log || { echo "simulation failed, see build.log and sim.log"; exit 1; }
echo "simulation passed"

// ==== bench/cdp_dp_model.svh ====
// CDP datapath expected results
`ifndef CDP_DP_MODEL_SVH
`define CDP_DP_MODEL_SVH

// limit to [lo, hi] and count the values that were limited
function automatic int clamp_cnt(input int val, input int lo, input int hi, inout int n);
  if (val < lo || val > hi) begin
    n++;
  end
  return (val < lo) ? lo : ((val > hi) ? hi : val);
endfunction

function automatic cdp_in_beat_t expected_beat(input cdp_in_beat_t x, input cdp_cfg_t c,
                                               input int tbl [LUT_DEPTH],
                                               output int n_oflow, output int n_sat);
  int           v [CDP_LANES];
  int           h, sum, idx, n_cvt;
  cdp_in_beat_t y;
  case (c.normalz_len)  // window spans 2h+1 lanes
    len3:    h = 1;
    len5:    h = 2;
    len7:    h = 3;
    default: h = 4;
  endcase
  n_oflow = 0;
  n_sat   = 0;
  n_cvt   = 0;
  for (int i = 0; i < CDP_LANES; i++) begin
    v[i] = clamp_cnt(((int'($signed(x.lane[i])) - int'($signed(c.datin_offset)))
                      * int'($signed(c.datin_scale))) >>> c.datin_shifter, -256, 255, n_cvt);
  end
  for (int i = 0; i < CDP_LANES; i++) begin
    sum = 0;
    for (int j = i - h; j <= i + h; j++) begin
      if (j >= 0 && j < CDP_LANES) begin
        sum += v[j] * v[j];  // lanes past the edge add nothing
      end
    end
    idx = sum >>> c.lut_index_select;
    if (idx >= LUT_DEPTH) begin
      idx = LUT_DEPTH - 1;  // clamp to last entry
      n_oflow++;
    end
    y.lane[i] = 8'(clamp_cnt((v[i] * tbl[idx]) >>> c.datout_shifter, -128, 127, n_sat));
  end
  return y;
endfunction

`endif

// ==== bench/cdp_dp_tb.sv ====
// CDP datapath testbench
`timescale 1ns/1ps

module cdp_dp_tb import cdp_pkg::*; ();

  localparam int LUT_AW      = 6;
  localparam int LUT_DEPTH   = 2 ** LUT_AW;
  localparam int N_BEATS     = 20;
  localparam int TOTAL_BEATS = 9 * N_BEATS;  // beats of tests 2 to 6
  localparam int TIMEOUT_CYC = TOTAL_BEATS * 20 + 2000;

  logic                  nvdla_core_clk = 1'b0;
  logic                  nvdla_core_rstn = 1'b0;
  cdp_cfg_t              cfg = '0;
  logic                  dp_in_valid = 1'b0;
  logic                  dp_in_ready, dp_out_valid;
  logic                  dp_out_ready = 1'b1;
  cdp_in_beat_t          dp_in_pd = '0;
  cdp_in_beat_t          dp_out_pd;
  logic [LUT_AW-1:0]     lut_addr = '0;
  logic [LUT_DATA_W-1:0] lut_data = '0;
  logic                  lut_data_trigger = 1'b0;
  logic [LUT_DATA_W-1:0] lut_rd_data;
  logic [31:0]           lut_oflow_count, out_saturation_count;

  int           seed = 32'hbb2b;
  int           rdy_seed = 32'hbb2b;
  int           shadow [LUT_DEPTH];  // expected table contents
  cdp_in_beat_t exp_q [$];
  int           acc_q [$];           // accept cycle per beat
  cdp_in_beat_t beats [N_BEATS];
  int           cyc = 0, mon_err = 0, chk_err = 0, n_in = 0, n_out = 0;
  int           exp_oflow = 0, exp_sat = 0, n_pass = 0, n_fail = 0;
  bit           lat_check = 1'b0, rand_ready = 1'b0;

  `include "cdp_dp_model.svh"

  cdp_dp #(.LUT_AW (LUT_AW)) u_cdp_dp (.*);

  always #10 nvdla_core_clk = ~nvdla_core_clk;

  always @(negedge nvdla_core_clk) begin
    dp_out_ready = rand_ready ? 1'($random(rdy_seed)) : 1'b1;
  end

  initial begin
    #(TIMEOUT_CYC * 20);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("RESULT: FAIL");
    $finish;
  end

  // ====================================================================
  // scoreboard
  // ====================================================================
  always @(posedge nvdla_core_clk) begin : scoreboard
    cdp_in_beat_t exp_beat;
    int           n_of, n_sa, acc, n_fly;
    logic         exp_rdy;
    cyc++;
    n_fly = exp_q.size();  // beats held in the four stages
    if (dp_in_valid && dp_in_ready) begin
      exp_beat = expected_beat(dp_in_pd, cfg, shadow, n_of, n_sa);
      exp_q.push_back(exp_beat);
      acc_q.push_back(cyc);
      exp_oflow += n_of;
      exp_sat   += n_sa;
      n_in++;
    end
    if (dp_out_valid && dp_out_ready) begin
      n_out++;
      assert (exp_q.size() > 0) else begin
        $display("output beat at %0t arrived with no beat outstanding", $time);
        mon_err++;
      end
      if (exp_q.size() > 0) begin
        exp_beat = exp_q.pop_front();
        acc      = acc_q.pop_front();
        assert (dp_out_pd == exp_beat) else begin
          $display("[FAIL] %0t dp_out_pd expected %h got %h", $time, exp_beat, dp_out_pd);
          mon_err++;
        end
        assert (!lat_check || cyc - acc == 4) else begin
          $display("[FAIL] %0t dp_out_valid latency expected 4 got %0d", $time, cyc - acc);
          mon_err++;
        end
      end
    end
    // input stalls exactly when all four stages are full and the output is held
    exp_rdy = !(n_fly == 4 && dp_out_valid && !dp_out_ready);
    assert (!nvdla_core_rstn || dp_in_ready == exp_rdy) else begin
      $display("[FAIL] %0t dp_in_ready expected %b got %b", $time, exp_rdy, dp_in_ready);
      mon_err++;
    end
  end

  // ====================================================================
  // stimulus tasks entered and left on a falling edge
  // ====================================================================
  task automatic write_lut(input int a, input int val);
    lut_addr         = LUT_AW'(a);
    lut_data         = LUT_DATA_W'(val);
    lut_data_trigger = 1'b1;
    shadow[a]        = val;
    @(negedge nvdla_core_clk);
    lut_data_trigger = 1'b0;
  endtask

  task automatic send_beat(input cdp_in_beat_t b);
    dp_in_valid = 1'b1;
    dp_in_pd    = b;
    @(posedge nvdla_core_clk);
    while (!dp_in_ready) begin
      @(posedge nvdla_core_clk);
    end
    @(negedge nvdla_core_clk);
    dp_in_valid = 1'b0;
  endtask

  task automatic fill_beats(input bit small_odd);
    for (int k = 0; k < N_BEATS; k++) begin
      for (int i = 0; i < CDP_LANES; i++) begin
        beats[k].lane[i] = (small_odd && k % 2 == 1) ? 8'($random(seed) % 4) : 8'($random(seed));
      end
    end
  endtask

  task automatic send_set(input bit gaps);
    for (int k = 0; k < N_BEATS; k++) begin
      while (gaps && 1'($random(seed))) begin
        @(negedge nvdla_core_clk);  // idle cycle
      end
      send_beat(beats[k]);
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge nvdla_core_clk);
    end
    @(negedge nvdla_core_clk);
  endtask

  task automatic end_test(input string name, input int err_before);
    drain();
    assert (lut_oflow_count == 32'(exp_oflow)) else begin
      $display("[FAIL] %0t lut_oflow_count expected %0d got %0d",
               $time, exp_oflow, lut_oflow_count);
      chk_err++;
    end
    assert (out_saturation_count == 32'(exp_sat)) else begin
      $display("[FAIL] %0t out_saturation_count expected %0d got %0d",
               $time, exp_sat, out_saturation_count);
      chk_err++;
    end
    assert (n_in == n_out) else begin
      $display("%0d beats went in but %0d came out", n_in, n_out);
      chk_err++;
    end
    if (mon_err + chk_err == err_before) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: errors found", name);
    end
  endtask

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin : main
    int err0;
    repeat (3) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    err0 = mon_err + chk_err;
    write_lut(3, 1234);
    write_lut(17, -42);
    write_lut(40, 32767);
    write_lut(41, -32768);
    write_lut(63, 555);
    for (int a = 0; a < LUT_DEPTH; a++) begin
      lut_addr = LUT_AW'(a);
      @(posedge nvdla_core_clk);
      assert (lut_rd_data == LUT_DATA_W'(shadow[a])) else begin
        $display("[FAIL] %0t lut_rd_data expected %h got %h",
                 $time, LUT_DATA_W'(shadow[a]), lut_rd_data);
        chk_err++;
      end
      @(negedge nvdla_core_clk);
    end
    end_test("table access", err0);

    err0 = mon_err + chk_err;
    for (int a = 0; a < LUT_DEPTH; a++) begin
      write_lut(a, a * 517 - 16000);  // ramp over the whole address
    end
    cfg.datin_scale      = 16'sd1;
    cfg.normalz_len      = len5;
    cfg.lut_index_select = 5'd11;
    cfg.datout_shifter   = 6'd14;  // keeps most lanes below saturation
    lat_check = 1'b1;
    fill_beats(1'b0);
    send_set(1'b0);
    end_test("ready held high", err0);
    lat_check = 1'b0;

    err0 = mon_err + chk_err;
    for (int l = 0; l < 4; l++) begin
      cfg.normalz_len = normalz_len_e'(l);
      send_set(1'b0);
      drain();
    end
    end_test("window lengths", err0);

    err0 = mon_err + chk_err;
    cfg.normalz_len      = len3;
    cfg.lut_index_select = 5'd0;
    fill_beats(1'b1);  // odd beats stay below the last index
    send_set(1'b0);
    end_test("overflow clamp", err0);

    err0 = mon_err + chk_err;
    for (int a = 0; a < LUT_DEPTH; a++) begin
      write_lut(a, (a % 2 == 1) ? -30000 - a : 30000 + a);
    end
    cfg.normalz_len      = len5;
    cfg.lut_index_select = 5'd11;
    cfg.datout_shifter   = 6'd2;
    fill_beats(1'b0);
    send_set(1'b0);
    end_test("output saturation", err0);

    err0 = mon_err + chk_err;
    cfg.datout_shifter = 6'd12;
    rand_ready = 1'b1;
    fill_beats(1'b0);
    send_set(1'b1);
    fill_beats(1'b0);
    send_set(1'b1);
    end_test("back-pressure", err0);
    rand_ready = 1'b0;

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && mon_err + chk_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/cdp_dp.sv ====
// CDP normalization datapath top
`timescale 1ns/1ps

module cdp_dp import cdp_pkg::*; #(
  parameter int LUT_AW = 6
) (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  cdp_cfg_t              cfg,
  input  logic                  dp_in_valid,
  output logic                  dp_in_ready,
  input  cdp_in_beat_t          dp_in_pd,
  output logic                  dp_out_valid,
  input  logic                  dp_out_ready,
  output cdp_in_beat_t          dp_out_pd,
  input  logic [LUT_AW-1:0]     lut_addr,
  input  logic [LUT_DATA_W-1:0] lut_data,
  input  logic                  lut_data_trigger,
  output logic [LUT_DATA_W-1:0] lut_rd_data,
  output logic [31:0]           lut_oflow_count,
  output logic [31:0]           out_saturation_count
);

  logic        cvt_valid, cvt_ready;
  cvt_beat_t   cvt_pd;
  logic        sqsum_valid, sqsum_ready;
  sqsum_beat_t sqsum_pd;
  logic        lut_valid, lut_ready;
  lut_beat_t   lut_pd;

  // ====================================================================
  // four stages, one register each
  // ====================================================================
  cdp_cvt_in u_cvt_in (
    .nvdla_core_clk (nvdla_core_clk), .nvdla_core_rstn (nvdla_core_rstn), .cfg (cfg),
    .in_valid (dp_in_valid), .in_ready (dp_in_ready), .in_pd (dp_in_pd),
    .out_valid (cvt_valid), .out_ready (cvt_ready), .out_pd (cvt_pd)
  );

  cdp_sqsum u_sqsum (
    .nvdla_core_clk (nvdla_core_clk), .nvdla_core_rstn (nvdla_core_rstn), .cfg (cfg),
    .in_valid (cvt_valid), .in_ready (cvt_ready), .in_pd (cvt_pd),
    .out_valid (sqsum_valid), .out_ready (sqsum_ready), .out_pd (sqsum_pd)
  );

  cdp_lut #(.LUT_AW (LUT_AW)) u_lut (
    .nvdla_core_clk (nvdla_core_clk), .nvdla_core_rstn (nvdla_core_rstn), .cfg (cfg),
    .in_valid (sqsum_valid), .in_ready (sqsum_ready), .in_pd (sqsum_pd),
    .out_valid (lut_valid), .out_ready (lut_ready), .out_pd (lut_pd),
    .lut_addr (lut_addr), .lut_data (lut_data), .lut_data_trigger (lut_data_trigger),
    .lut_rd_data (lut_rd_data), .lut_oflow_count (lut_oflow_count)
  );

  cdp_cvt_out u_cvt_out (
    .nvdla_core_clk (nvdla_core_clk), .nvdla_core_rstn (nvdla_core_rstn), .cfg (cfg),
    .in_valid (lut_valid), .in_ready (lut_ready), .in_pd (lut_pd),
    .out_valid (dp_out_valid), .out_ready (dp_out_ready), .out_pd (dp_out_pd),
    .out_saturation_count (out_saturation_count)
  );

endmodule

// ==== source/cdp_cvt_out.sv ====
// CDP output conversion stage
`timescale 1ns/1ps

module cdp_cvt_out import cdp_pkg::*; (
  input  logic         nvdla_core_clk,
  input  logic         nvdla_core_rstn,
  input  cdp_cfg_t     cfg,
  input  logic         in_valid,
  output logic         in_ready,
  input  lut_beat_t    in_pd,
  output logic         out_valid,
  input  logic         out_ready,
  output cdp_in_beat_t out_pd,
  output logic [31:0]  out_saturation_count
);

  logic signed [24:0]   prod [CDP_LANES];  // 9b x 16b
  logic signed [24:0]   shf [CDP_LANES];
  logic [CDP_LANES-1:0] sat;
  logic [3:0]           sat_n;
  cdp_in_beat_t         pd_nxt;
  logic                 xfer;

  always_comb begin
    sat_n = '0;
    for (int i = 0; i < CDP_LANES; i++) begin
      prod[i] = 25'($signed(in_pd.cvt.v[i])) * 25'($signed(in_pd.lut[i]));
      shf[i]  = prod[i] >>> cfg.datout_shifter;
      if (shf[i] > 25'sd127) begin
        pd_nxt.lane[i] = 8'sd127;
        sat[i]         = 1'b1;
      end else if (shf[i] < -25'sd128) begin
        pd_nxt.lane[i] = -8'sd128;
        sat[i]         = 1'b1;
      end else begin
        pd_nxt.lane[i] = int8_t'(shf[i][7:0]);
        sat[i]         = 1'b0;
      end
      sat_n = sat_n + 4'(sat[i]);
    end
  end

  // ====================================================================
  // output register and saturation counter
  // ====================================================================
  assign in_ready = !out_valid || out_ready;
  assign xfer     = in_valid && in_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid            <= 1'b0;
      out_saturation_count <= '0;
    end else if (xfer) begin
      out_valid            <= 1'b1;
      out_saturation_count <= out_saturation_count + 32'(sat_n);
    end else if (out_ready) begin
      out_valid <= 1'b0;  // taken downstream
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (xfer) begin
      out_pd <= pd_nxt;
    end
  end

endmodule

// ==== source/cdp_lut.sv ====
// CDP lookup table stage
`timescale 1ns/1ps

module cdp_lut import cdp_pkg::*; #(
  parameter int LUT_AW = 6
) (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  cdp_cfg_t              cfg,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  sqsum_beat_t           in_pd,
  output logic                  out_valid,
  input  logic                  out_ready,
  output lut_beat_t             out_pd,
  input  logic [LUT_AW-1:0]     lut_addr,
  input  logic [LUT_DATA_W-1:0] lut_data,
  input  logic                  lut_data_trigger,
  output logic [LUT_DATA_W-1:0] lut_rd_data,
  output logic [31:0]           lut_oflow_count
);

  localparam int LUT_DEPTH = 2 ** LUT_AW;
  localparam int LUT_LAST  = LUT_DEPTH - 1;

  logic [LUT_DATA_W-1:0] table_q [LUT_DEPTH];
  logic [SQSUM_W-1:0]    idx_full [CDP_LANES];
  logic [LUT_AW-1:0]     idx [CDP_LANES];
  logic [CDP_LANES-1:0]  oflow;    // lane clamped to last entry
  logic [3:0]            oflow_n;
  lut_beat_t             pd_nxt;
  logic                  xfer;

  // ====================================================================
  // table write and readback
  // ====================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int k = 0; k < LUT_DEPTH; k++) begin
        table_q[k] <= '0;
      end
    end else if (lut_data_trigger) begin
      table_q[lut_addr] <= lut_data;
    end
  end

  assign lut_rd_data = table_q[lut_addr];

  // ====================================================================
  // index, clamp and lookup
  // ====================================================================
  always_comb begin
    pd_nxt.cvt = in_pd.cvt;
    oflow_n    = '0;
    for (int i = 0; i < CDP_LANES; i++) begin
      idx_full[i]   = in_pd.sum[i] >> cfg.lut_index_select;
      oflow[i]      = idx_full[i] > SQSUM_W'(LUT_LAST);
      idx[i]        = oflow[i] ? LUT_AW'(LUT_LAST) : idx_full[i][LUT_AW-1:0];
      pd_nxt.lut[i] = lut_val_t'(table_q[idx[i]]);
      oflow_n       = oflow_n + 4'(oflow[i]);
    end
  end

  assign in_ready = !out_valid || out_ready;
  assign xfer     = in_valid && in_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid       <= 1'b0;
      lut_oflow_count <= '0;
    end else if (xfer) begin
      out_valid       <= 1'b1;
      lut_oflow_count <= lut_oflow_count + 32'(oflow_n);  // free-running
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (xfer) begin
      out_pd <= pd_nxt;
    end
  end

endmodule

// ==== source/cdp_sqsum.sv ====
// CDP windowed square sum
`timescale 1ns/1ps

module cdp_sqsum import cdp_pkg::*; (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  cdp_cfg_t    cfg,
  input  logic        in_valid,
  output logic        in_ready,
  input  cvt_beat_t   in_pd,
  output logic        out_valid,
  input  logic        out_ready,
  output sqsum_beat_t out_pd
);

  int                  half;              // window half width
  logic signed [17:0]  vx [CDP_LANES];    // sign-extended lane
  logic signed [17:0]  sq_full [CDP_LANES];
  logic [16:0]         sq [CDP_LANES];    // square is never above 2^16
  sqsum_beat_t         pd_nxt;

  always_comb begin
    case (cfg.normalz_len)
      len3:    half = 1;
      len5:    half = 2;
      len7:    half = 3;
      default: half = 4;
    endcase
  end

  always_comb begin
    for (int j = 0; j < CDP_LANES; j++) begin
      vx[j]      = 18'($signed(in_pd.v[j]));
      sq_full[j] = vx[j] * vx[j];
      sq[j]      = sq_full[j][16:0];
    end
  end

  // lanes outside 0..7 simply never enter the sum
  always_comb begin
    pd_nxt.cvt = in_pd;
    for (int i = 0; i < CDP_LANES; i++) begin
      pd_nxt.sum[i] = '0;
      for (int j = 0; j < CDP_LANES; j++) begin
        if ((j - i) <= half && (i - j) <= half) begin
          pd_nxt.sum[i] = pd_nxt.sum[i] + SQSUM_W'(sq[j]);
        end
      end
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid && in_ready) begin
      out_pd <= pd_nxt;  // sums travel with converted lanes
    end
  end

endmodule

// ==== source/cdp_cvt_in.sv ====
// CDP input conversion stage
`timescale 1ns/1ps

module cdp_cvt_in import cdp_pkg::*; (
  input  logic         nvdla_core_clk,
  input  logic         nvdla_core_rstn,
  input  cdp_cfg_t     cfg,
  input  logic         in_valid,
  output logic         in_ready,
  input  cdp_in_beat_t in_pd,
  output logic         out_valid,
  input  logic         out_ready,
  output cvt_beat_t    out_pd
);

  cvt_beat_t pd_nxt;

  // (x - offset) * scale >>> shift, clipped to 9 bits
  function automatic cvt_t cvt_lane(input int8_t x, input cdp_cfg_t c);
    logic signed [8:0]  diff;
    logic signed [24:0] prod;
    logic signed [24:0] shf;
    diff = 9'($signed(x)) - 9'($signed(c.datin_offset));
    prod = 25'(diff) * 25'($signed(c.datin_scale));
    shf  = prod >>> c.datin_shifter;
    if (shf > 25'sd255) begin
      return 9'sd255;
    end else if (shf < -25'sd256) begin
      return -9'sd256;
    end
    return cvt_t'(shf[CVT_W-1:0]);
  endfunction

  always_comb begin
    for (int i = 0; i < CDP_LANES; i++) begin
      pd_nxt.v[i] = cvt_lane(in_pd.lane[i], cfg);
    end
  end

  // one-deep output register
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // drained
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid && in_ready) begin
      out_pd <= pd_nxt;
    end
  end

endmodule

// ==== source/cdp_pkg.sv ====
// CDP datapath shared types
package cdp_pkg;

  // ====================================================================
  // widths
  // ====================================================================
  localparam int CDP_LANES  = 8;   // channel lanes per beat
  localparam int CVT_W      = 9;   // converted value, signed
  localparam int SQSUM_W    = 20;  // 9 squares of 2^16 fit here
  localparam int LUT_DATA_W = 16;  // table entry, signed

  // window length across channels
  typedef enum logic [1:0] {
    len3 = 2'd0,
    len5 = 2'd1,
    len7 = 2'd2,
    len9 = 2'd3
  } normalz_len_e;

  // static config, must not change while beats are in flight
  typedef struct packed {
    logic signed [7:0]  datin_offset;
    logic signed [15:0] datin_scale;
    logic [4:0]         datin_shifter;
    normalz_len_e       normalz_len;
    logic [4:0]         lut_index_select;
    logic [5:0]         datout_shifter;
  } cdp_cfg_t;

  typedef logic signed [7:0]            int8_t;
  typedef logic signed [CVT_W-1:0]      cvt_t;
  typedef logic [SQSUM_W-1:0]           sqsum_t;
  typedef logic signed [LUT_DATA_W-1:0] lut_val_t;

  // ====================================================================
  // beat payloads
  // ====================================================================
  typedef struct packed {
    int8_t [CDP_LANES-1:0] lane;  // raw int8 channels
  } cdp_in_beat_t;

  typedef struct packed {
    cvt_t [CDP_LANES-1:0] v;  // converted channels
  } cvt_beat_t;

  typedef struct packed {
    cvt_beat_t              cvt;
    sqsum_t [CDP_LANES-1:0] sum;  // windowed square sums
  } sqsum_beat_t;

  typedef struct packed {
    cvt_beat_t                cvt;
    lut_val_t [CDP_LANES-1:0] lut;  // looked-up table values
  } lut_beat_t;

endpackage
